//--- verification/rsa_vectors.txt
# test <name> | load <lane> <addr hex> <data hex> | start <k>
# expect <lane> <C[lane][0..3] hex> | end reads back C, A and B
test k1_outer
load 0 00 00000001
load 1 00 00000002
load 2 00 00000003
load 3 00 00000004
load 0 10 00000005
load 1 10 00000006
load 2 10 00000007
load 3 10 00000008
start 1
expect 0 00000005 00000006 00000007 00000008
expect 1 0000000a 0000000c 0000000e 00000010
expect 2 0000000f 00000012 00000015 00000018
expect 3 00000014 00000018 0000001c 00000020
end
test k2_signed_wrap
load 0 00 00000001
load 0 01 00000002
load 1 00 ffffffff
load 1 01 00000003
load 2 00 00010000
load 2 01 00010000
load 3 00 00000002
load 3 01 fffffffe
load 0 10 00000003
load 0 11 00000005
load 1 10 ffffffff
load 1 11 00000002
load 2 10 00010000
load 2 11 00010000
load 3 10 00000004
load 3 11 fffffffd
start 2
expect 0 0000000d 00000003 00030000 fffffffe
expect 1 0000000c 00000007 00020000 fffffff3
expect 2 00080000 00010000 00000000 00010000
expect 3 fffffffc fffffffa 00000000 0000000e
end

//--- filelist.f
rtl/rsa_pkg.sv
rtl/bank_rd_if.sv
rtl/rsa_step_counter.sv
rtl/rsa_seq_fsm.sv
rtl/rsa_operand_bank.sv
rtl/rsa_operand_skew.sv
rtl/rsa_pe.sv
rtl/rsa_pe_array.sv
rtl/rsa_top.sv
verification/rsa_tb.sv

//--- verification/rsa_tb.sv
module rsa_tb;

  logic clk;
  logic sys_rst;
  logic i_start;
  logic [rsa_pkg::KW-1:0] i_k_len;
  logic o_busy;
  logic o_done;
  logic i_ld_we;
  logic [1:0] i_ld_lane;
  rsa_pkg::addr_t i_ld_addr;
  rsa_pkg::word_t i_ld_data;
  rsa_pkg::addr_t i_rd_addr;
  logic [rsa_pkg::LANES*rsa_pkg::DATA_DW-1:0] o_rd_data;

  // host copy of every lane, expected C, last host read
  logic [31:0] shadow [rsa_pkg::LANES][2**rsa_pkg::AW];
  logic [31:0] exp_c [rsa_pkg::LANES][rsa_pkg::COLS];
  logic [31:0] rd_words [rsa_pkg::LANES];
  string test_name = "reset";
  int seed = 32'h1475;
  int done_count = 0;
  int budget = 0;
  int wait_cycles = 0;
  bit waiting = 1'b0;

  rsa_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch in test %s, %s: expected %h, actual %h",
               test_name, what, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  // one host write to the given lane and address
  task automatic host_load(input int lane, input int addr, input logic [31:0] data);
    @(negedge clk);
    i_ld_we   = 1'b1;
    i_ld_lane = lane[1:0];
    i_ld_addr = rsa_pkg::addr_t'(addr);
    i_ld_data = data;
    @(negedge clk);
    i_ld_we = 1'b0;
    shadow[lane][addr] = data;
  endtask

  // data shows one cycle after the address
  task automatic host_read(input int addr);
    @(negedge clk);
    i_rd_addr = rsa_pkg::addr_t'(addr);
    @(negedge clk);
    for (int l = 0; l < rsa_pkg::LANES; l++) begin
      rd_words[l] = o_rd_data[l*rsa_pkg::DATA_DW +: rsa_pkg::DATA_DW];
    end
  endtask

  // C[i][j] is the sum over n of A[i][n] * B[n][j] modulo 2^32
  task automatic fill_model(input int k);
    logic [31:0] acc;
    for (int i = 0; i < rsa_pkg::ROWS; i++) begin
      for (int j = 0; j < rsa_pkg::COLS; j++) begin
        acc = '0;
        for (int n = 0; n < k; n++) begin
          acc = acc + shadow[i][rsa_pkg::A_BASE+n] * shadow[j][rsa_pkg::B_BASE+n];
        end
        exp_c[i][j] = acc;
      end
    end
  endtask

  // poke drives a second start and a host load while busy
  task automatic run_array(input int k, input bit poke);
    logic [31:0] old_word;
    old_word   = shadow[0][rsa_pkg::A_BASE];
    done_count = 0;
    budget += k + rsa_pkg::FLUSH_LEN + rsa_pkg::COLS + 50;
    @(negedge clk);
    i_start = 1'b1;
    i_k_len = rsa_pkg::KW'(k);
    @(negedge clk);
    i_start = 1'b0;
    check_value("busy after start", 1, o_busy);
    if (poke) begin
      i_start   = 1'b1;
      i_k_len   = rsa_pkg::KW'(k + 3);
      i_ld_we   = 1'b1;
      i_ld_lane = 2'd0;
      i_ld_addr = rsa_pkg::addr_t'(rsa_pkg::A_BASE);
      i_ld_data = ~old_word;
      @(negedge clk);
      i_start = 1'b0;
      i_ld_we = 1'b0;
    end
    waiting = 1'b1;
    while (!o_done) @(negedge clk);
    waiting = 1'b0;
    check_value("busy at done", 0, o_busy);
    // long enough for a wrongly accepted second run to finish
    repeat (30) @(negedge clk);
    check_value("done pulse count", 1, done_count);
  endtask

  task automatic check_c_region();
    for (int j = 0; j < rsa_pkg::COLS; j++) begin
      host_read(rsa_pkg::C_BASE + j);
      for (int l = 0; l < rsa_pkg::LANES; l++) begin
        check_value($sformatf("C lane %0d col %0d", l, j), exp_c[l][j], rd_words[l]);
      end
    end
  endtask

  // A and B regions must match what the host loaded
  task automatic check_operand_regions();
    for (int a = 0; a < rsa_pkg::C_BASE; a++) begin
      host_read(a);
      for (int l = 0; l < rsa_pkg::LANES; l++) begin
        check_value($sformatf("operand lane %0d addr %0d", l, a), shadow[l][a], rd_words[l]);
      end
    end
  endtask

  task automatic run_random(input int k, input bit poke);
    for (int n = 0; n < k; n++) begin
      for (int l = 0; l < rsa_pkg::LANES; l++) begin
        host_load(l, rsa_pkg::A_BASE + n, $random(seed));
        host_load(l, rsa_pkg::B_BASE + n, $random(seed));
      end
    end
    fill_model(k);
    run_array(k, poke);
    check_c_region();
    check_operand_regions();
  endtask

  task automatic read_vectors();
    int fd;
    int code;
    int k;
    int lane;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] c [rsa_pkg::COLS];
    string tag;
    string line;
    bit bad_rec;
    bad_rec = 1'b0;
    fd = $fopen("verification/rsa_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open verification/rsa_vectors.txt");
      $display("RESULT: FAIL");
      $fatal(1, "no vector file");
    end
    while (!bad_rec && $fscanf(fd, "%s", tag) == 1) begin
      if (tag == "#") begin
        code = $fgets(line, fd);
      end else if (tag == "test") begin
        code = $fscanf(fd, "%s", test_name);
        bad_rec = (code != 1);
      end else if (tag == "load") begin
        code = $fscanf(fd, "%d %h %h", lane, addr, data);
        bad_rec = (code != 3) || (lane < 0) || (lane >= rsa_pkg::LANES);
        if (!bad_rec) begin
          host_load(lane, addr, data);
        end
      end else if (tag == "start") begin
        code = $fscanf(fd, "%d", k);
        bad_rec = (code != 1);
        if (!bad_rec) begin
          run_array(k, 1'b0);
        end
      end else if (tag == "expect") begin
        code = $fscanf(fd, "%d %h %h %h %h", lane, c[0], c[1], c[2], c[3]);
        bad_rec = (code != 5) || (lane < 0) || (lane >= rsa_pkg::LANES);
        if (!bad_rec) begin
          for (int j = 0; j < rsa_pkg::COLS; j++) begin
            exp_c[lane][j] = c[j];
          end
        end
      end else if (tag == "end") begin
        check_c_region();
        check_operand_regions();
      end else begin
        bad_rec = 1'b1;
      end
    end
    $fclose(fd);
    if (bad_rec) begin
      $display("malformed or unknown record %s in the vector file", tag);
      $display("RESULT: FAIL");
      $fatal(1, "bad vector file");
    end
  endtask

  // done pulses sampled away from the rising edge
  always @(negedge clk) begin
    if (o_done) begin
      done_count++;
    end
  end

  initial begin : watchdog
    bit expired;
    expired = 1'b0;
    while (!expired) begin
      @(negedge clk);
      if (waiting) begin
        wait_cycles++;
      end
      expired = (wait_cycles > budget);
    end
    $display("timeout in test %s, o_done never came", test_name);
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int k;
    sys_rst   = 1'b1;
    i_start   = 1'b0;
    i_k_len   = '0;
    i_ld_we   = 1'b0;
    i_ld_lane = '0;
    i_ld_addr = '0;
    i_ld_data = '0;
    i_rd_addr = '0;
    for (int l = 0; l < rsa_pkg::LANES; l++) begin
      for (int a = 0; a < 2**rsa_pkg::AW; a++) begin
        shadow[l][a] = '0;
      end
    end
    repeat (10) @(negedge clk);
    sys_rst = 1'b0;
    check_value("busy after reset", 0, o_busy);
    check_value("done after reset", 0, o_done);
    // whole memory reads zero after reset
    for (int a = 0; a < 2**rsa_pkg::AW; a++) begin
      host_read(a);
      for (int l = 0; l < rsa_pkg::LANES; l++) begin
        check_value($sformatf("reset lane %0d addr %0d", l, a), 0, rd_words[l]);
      end
    end
    read_vectors();
    for (int t = 0; t < 10; t++) begin
      test_name = $sformatf("random_%0d", t);
      k = 1 + ($unsigned($random(seed)) % rsa_pkg::K_MAX);
      run_random(k, 1'b0);
    end
    // k of 6 leaves room for the ignored k of 9
    test_name = "busy_restart";
    run_random(6, 1'b1);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- rtl/rsa_top.sv
module rsa_top (
  input  logic                                         clk,
  input  logic                                         sys_rst,
  input  logic                                         i_start,
  input  logic [rsa_pkg::KW-1:0]                       i_k_len,
  output logic                                         o_busy,
  output logic                                         o_done,
  input  logic                                         i_ld_we,
  input  logic [1:0]                                   i_ld_lane,
  input  rsa_pkg::addr_t                               i_ld_addr,
  input  rsa_pkg::word_t                               i_ld_data,
  input  rsa_pkg::addr_t                               i_rd_addr,
  output logic [rsa_pkg::LANES*rsa_pkg::DATA_DW-1:0]   o_rd_data
);

  // sequencer to array and bank
  logic pe_clear;
  logic pe_shift;
  logic feed_valid;
  logic wb_we;
  rsa_pkg::addr_t wb_addr;

  // phase counter
  logic cnt_clear;
  logic cnt_step;
  logic cnt_last;
  logic [rsa_pkg::KW-1:0] cnt_limit;
  logic [rsa_pkg::KW-1:0] cnt;

  // skewed operands and drained results
  rsa_pkg::word_t [rsa_pkg::ROWS-1:0] a_skew;
  rsa_pkg::word_t [rsa_pkg::COLS-1:0] b_skew;
  rsa_pkg::word_t [rsa_pkg::ROWS-1:0] west_acc;

  bank_rd_if rd_bus ();

  rsa_seq_fsm u_seq (
    .clk (clk), .sys_rst (sys_rst), .i_start (i_start), .i_k_len (i_k_len),
    .o_busy (o_busy), .o_done (o_done), .rd (rd_bus.seq),
    .o_wb_we (wb_we), .o_wb_addr (wb_addr),
    .o_pe_clear (pe_clear), .o_pe_shift (pe_shift), .o_feed_valid (feed_valid),
    .o_cnt_clear (cnt_clear), .o_cnt_step (cnt_step), .o_cnt_limit (cnt_limit),
    .i_cnt (cnt), .i_cnt_last (cnt_last)
  );

  rsa_step_counter u_cnt (
    .clk (clk), .sys_rst (sys_rst), .i_clear (cnt_clear), .i_step (cnt_step),
    .i_limit (cnt_limit), .o_count (cnt), .o_last (cnt_last)
  );

  // host loads during a run are dropped
  rsa_operand_bank u_bank (
    .clk (clk), .sys_rst (sys_rst), .rd (rd_bus.bank),
    .i_wb_we (wb_we), .i_wb_addr (wb_addr), .i_wb_data (west_acc),
    .i_ld_we (i_ld_we & ~o_busy), .i_ld_lane (i_ld_lane),
    .i_ld_addr (i_ld_addr), .i_ld_data (i_ld_data),
    .i_rd_addr (i_rd_addr), .o_rd_data (o_rd_data)
  );

  // A rows into the west edge
  rsa_operand_skew #(.NLANES (rsa_pkg::ROWS)) u_skew_a (
    .clk (clk), .sys_rst (sys_rst), .i_valid (feed_valid),
    .i_data (rd_bus.rdata_a), .o_data (a_skew)
  );

  // B columns into the south edge
  rsa_operand_skew #(.NLANES (rsa_pkg::COLS)) u_skew_b (
    .clk (clk), .sys_rst (sys_rst), .i_valid (feed_valid),
    .i_data (rd_bus.rdata_b), .o_data (b_skew)
  );

  rsa_pe_array u_array (
    .clk (clk), .sys_rst (sys_rst), .i_clear (pe_clear), .i_shift (pe_shift),
    .i_west (a_skew), .i_south (b_skew), .o_west_acc (west_acc)
  );

endmodule

//--- rtl/rsa_pe_array.sv
module rsa_pe_array (
  input  logic                                clk,
  input  logic                                sys_rst,
  input  logic                                i_clear,
  input  logic                                i_shift,
  input  rsa_pkg::word_t [rsa_pkg::ROWS-1:0]  i_west,
  input  rsa_pkg::word_t [rsa_pkg::COLS-1:0]  i_south,
  output rsa_pkg::word_t [rsa_pkg::ROWS-1:0]  o_west_acc
);

  // per cell outputs, row 0 is the south edge, column 0 the west edge
  rsa_pkg::word_t east_w  [rsa_pkg::ROWS][rsa_pkg::COLS];
  rsa_pkg::word_t north_w [rsa_pkg::ROWS][rsa_pkg::COLS];
  rsa_pkg::word_t acc_w   [rsa_pkg::ROWS][rsa_pkg::COLS];

  for (genvar r = 0; r < rsa_pkg::ROWS; r++) begin : g_row
    for (genvar c = 0; c < rsa_pkg::COLS; c++) begin : g_col
      rsa_pkg::word_t west_in;
      rsa_pkg::word_t south_in;
      rsa_pkg::word_t east_acc_in;

      // A from the west edge or the cell to the left
      if (c == 0) begin : g_w_edge
        assign west_in = i_west[r];
      end else begin : g_w_link
        assign west_in = east_w[r][c-1];
      end

      // B from the south edge or the cell below
      if (r == 0) begin : g_s_edge
        assign south_in = i_south[c];
      end else begin : g_s_link
        assign south_in = north_w[r-1][c];
      end

      // last column shifts in zeros while draining
      if (c == rsa_pkg::COLS - 1) begin : g_e_edge
        assign east_acc_in = '0;
      end else begin : g_e_link
        assign east_acc_in = acc_w[r][c+1];
      end

      rsa_pe u_pe (
        .clk        (clk),
        .sys_rst    (sys_rst),
        .i_clear    (i_clear),
        .i_shift    (i_shift),
        .i_west     (west_in),
        .i_south    (south_in),
        .i_east_acc (east_acc_in),
        .o_east     (east_w[r][c]),
        .o_north    (north_w[r][c]),
        .o_acc      (acc_w[r][c])
      );
    end

    // row result leaves through column 0
    assign o_west_acc[r] = acc_w[r][0];
  end

endmodule

//--- rtl/rsa_pe.sv
module rsa_pe (
  input  logic            clk,
  input  logic            sys_rst,
  input  logic            i_clear,
  input  logic            i_shift,
  input  rsa_pkg::word_t  i_west,
  input  rsa_pkg::word_t  i_south,
  input  rsa_pkg::word_t  i_east_acc,
  output rsa_pkg::word_t  o_east,
  output rsa_pkg::word_t  o_north,
  output rsa_pkg::word_t  o_acc
);

  rsa_pkg::word_t prod;

  // low 32 bits of the product, wraps like the sum
  assign prod = i_west * i_south;

  // operands hop one cell per cycle
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_east  <= '0;
      o_north <= '0;
    end else begin
      o_east  <= i_west;
      o_north <= i_south;
    end
  end

  // output stationary accumulator
  // shift hands results west, one column per cycle
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_acc <= '0;
    end else if (i_clear) begin
      o_acc <= '0;
    end else if (i_shift) begin
      o_acc <= i_east_acc;
    end else begin
      o_acc <= o_acc + prod;
    end
  end

endmodule

//--- rtl/rsa_operand_skew.sv
module rsa_operand_skew #(
  parameter int NLANES = rsa_pkg::ROWS
) (
  input  logic                           clk,
  input  logic                           sys_rst,
  input  logic                           i_valid,
  input  rsa_pkg::word_t [NLANES-1:0]    i_data,
  output rsa_pkg::word_t [NLANES-1:0]    o_data
);

  logic valid_q;
  rsa_pkg::word_t [NLANES-1:0] head;

  // valid lines up with the bank read data
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_valid;
    end
  end

  // idle cycles feed zeros, no effect on the sums
  assign head = valid_q ? i_data : '0;

  for (genvar i = 0; i < NLANES; i++) begin : g_lane
    if (i == 0) begin : g_direct
      // lane 0 enters the grid unskewed
      assign o_data[0] = head[0];
    end else begin : g_delay
      rsa_pkg::word_t [i-1:0] pipe;

      // i stage shift line
      always_ff @(posedge clk) begin
        if (sys_rst) begin
          pipe <= '0;
        end else begin
          pipe[0] <= head[i];
          for (int s = 1; s < i; s++) begin
            pipe[s] <= pipe[s-1];
          end
        end
      end

      assign o_data[i] = pipe[i-1];
    end
  end

endmodule

//--- rtl/rsa_operand_bank.sv
module rsa_operand_bank (
  input  logic                                 clk,
  input  logic                                 sys_rst,
  bank_rd_if.bank                              rd,
  input  logic                                 i_wb_we,
  input  rsa_pkg::addr_t                       i_wb_addr,
  input  rsa_pkg::word_t [rsa_pkg::LANES-1:0]  i_wb_data,
  input  logic                                 i_ld_we,
  input  logic [1:0]                           i_ld_lane,
  input  rsa_pkg::addr_t                       i_ld_addr,
  input  rsa_pkg::word_t                       i_ld_data,
  input  rsa_pkg::addr_t                       i_rd_addr,
  output rsa_pkg::word_t [rsa_pkg::LANES-1:0]  o_rd_data
);

  // lane x word register memory
  rsa_pkg::word_t mem [rsa_pkg::LANES][2**rsa_pkg::AW];

  // single write port
  // writeback hits all lanes at once and beats a host load
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      for (int l = 0; l < rsa_pkg::LANES; l++) begin
        for (int a = 0; a < 2**rsa_pkg::AW; a++) begin
          mem[l][a] <= '0;
        end
      end
    end else if (i_wb_we) begin
      for (int l = 0; l < rsa_pkg::LANES; l++) begin
        mem[l][i_wb_addr] <= i_wb_data[l];
      end
    end else if (i_ld_we) begin
      mem[i_ld_lane][i_ld_addr] <= i_ld_data;
    end
  end

  // array read, A and B side by side, holds between reads
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      rd.rdata_a <= '0;
      rd.rdata_b <= '0;
    end else if (rd.rd_en) begin
      for (int l = 0; l < rsa_pkg::LANES; l++) begin
        rd.rdata_a[l] <= mem[l][rd.rd_addr_a];
        rd.rdata_b[l] <= mem[l][rd.rd_addr_b];
      end
    end
  end

  // host read, one cycle
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_rd_data <= '0;
    end else begin
      for (int l = 0; l < rsa_pkg::LANES; l++) begin
        o_rd_data[l] <= mem[l][i_rd_addr];
      end
    end
  end

endmodule

//--- rtl/rsa_seq_fsm.sv
module rsa_seq_fsm (
  input  logic                    clk,
  input  logic                    sys_rst,
  input  logic                    i_start,
  input  logic [rsa_pkg::KW-1:0]  i_k_len,
  output logic                    o_busy,
  output logic                    o_done,
  bank_rd_if.seq                  rd,
  output logic                    o_wb_we,
  output rsa_pkg::addr_t          o_wb_addr,
  output logic                    o_pe_clear,
  output logic                    o_pe_shift,
  output logic                    o_feed_valid,
  output logic                    o_cnt_clear,
  output logic                    o_cnt_step,
  output logic [rsa_pkg::KW-1:0]  o_cnt_limit,
  input  logic [rsa_pkg::KW-1:0]  i_cnt,
  input  logic                    i_cnt_last
);

  rsa_pkg::seq_state_t state;
  rsa_pkg::seq_state_t state_nxt;
  logic [rsa_pkg::KW-1:0] k_eff;
  logic [rsa_pkg::KW-1:0] k_q;
  logic start_ok;

  // start only counts in IDLE
  assign start_ok = (state == rsa_pkg::IDLE) && i_start;

  // k above the A region depth is clipped
  always_comb begin
    if (i_k_len > rsa_pkg::KW'(rsa_pkg::K_MAX)) begin
      k_eff = rsa_pkg::KW'(rsa_pkg::K_MAX);
    end else begin
      k_eff = i_k_len;
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state <= rsa_pkg::IDLE;
      k_q   <= '0;
    end else begin
      state <= state_nxt;
      // k is sampled with the start pulse
      if (start_ok) begin
        k_q <= k_eff;
      end
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      rsa_pkg::IDLE: begin
        // k of zero has nothing to feed, C comes out all zero
        if (start_ok) begin
          state_nxt = (k_eff == '0) ? rsa_pkg::FLUSH : rsa_pkg::FEED;
        end
      end
      rsa_pkg::FEED: begin
        if (i_cnt_last) begin
          state_nxt = rsa_pkg::FLUSH;
        end
      end
      rsa_pkg::FLUSH: begin
        if (i_cnt_last) begin
          state_nxt = rsa_pkg::DRAIN;
        end
      end
      rsa_pkg::DRAIN: begin
        if (i_cnt_last) begin
          state_nxt = rsa_pkg::DONE;
        end
      end
      default: begin
        state_nxt = rsa_pkg::IDLE;
      end
    endcase
  end

  // busy drops when done pulses
  assign o_busy = (state == rsa_pkg::FEED) || (state == rsa_pkg::FLUSH) ||
                  (state == rsa_pkg::DRAIN);
  assign o_done = (state == rsa_pkg::DONE);

  // accumulators cleared on the accepted start edge
  assign o_pe_clear = start_ok;

  // phase counter, restarted at every phase boundary
  assign o_cnt_clear = !o_busy || i_cnt_last;
  assign o_cnt_step  = o_busy;

  always_comb begin
    case (state)
      rsa_pkg::FEED:  o_cnt_limit = k_q;
      rsa_pkg::FLUSH: o_cnt_limit = rsa_pkg::KW'(rsa_pkg::FLUSH_LEN);
      rsa_pkg::DRAIN: o_cnt_limit = rsa_pkg::KW'(rsa_pkg::COLS);
      default:        o_cnt_limit = '0;
    endcase
  end

  // feed reads A[.][n] and B[n][.] at count n
  assign rd.rd_en      = (state == rsa_pkg::FEED);
  assign rd.rd_addr_a  = rsa_pkg::addr_t'(rsa_pkg::A_BASE + i_cnt);
  assign rd.rd_addr_b  = rsa_pkg::addr_t'(rsa_pkg::B_BASE + i_cnt);
  assign o_feed_valid  = (state == rsa_pkg::FEED);

  // drain writes column n of C on count n
  assign o_pe_shift = (state == rsa_pkg::DRAIN);
  assign o_wb_we    = (state == rsa_pkg::DRAIN);
  assign o_wb_addr  = rsa_pkg::addr_t'(rsa_pkg::C_BASE + i_cnt);

endmodule

//--- rtl/rsa_step_counter.sv
module rsa_step_counter (
  input  logic                    clk,
  input  logic                    sys_rst,
  input  logic                    i_clear,
  input  logic                    i_step,
  input  logic [rsa_pkg::KW-1:0]  i_limit,
  output logic [rsa_pkg::KW-1:0]  o_count,
  output logic                    o_last
);

  logic [rsa_pkg::KW-1:0] limit_m1;

  // last count of the phase is limit minus one
  assign limit_m1 = rsa_pkg::KW'(i_limit - 1'b1);

  // clear wins over step
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_count <= '0;
    end else if (i_clear) begin
      o_count <= '0;
    end else if (i_step) begin
      o_count <= o_count + 1'b1;
    end
  end

  // combinational, lets the FSM leave the phase on this cycle
  assign o_last = (o_count == limit_m1);

endmodule

//--- rtl/bank_rd_if.sv
interface bank_rd_if;

  // read strobe from the sequencer
  logic rd_en;

  // A and B word addresses, same address in every lane
  rsa_pkg::addr_t rd_addr_a;
  rsa_pkg::addr_t rd_addr_b;

  // one word per lane, valid the cycle after rd_en
  // held while rd_en is low
  rsa_pkg::word_t [rsa_pkg::LANES-1:0] rdata_a;
  rsa_pkg::word_t [rsa_pkg::LANES-1:0] rdata_b;

  // sequencer side, issues reads
  modport seq (
    output rd_en,
    output rd_addr_a,
    output rd_addr_b
  );

  // bank side, returns data
  modport bank (
    input  rd_en,
    input  rd_addr_a,
    input  rd_addr_b,
    output rdata_a,
    output rdata_b
  );

endinterface

//--- rtl/rsa_pkg.sv
package rsa_pkg;

  // grid shape
  localparam int ROWS = 4;
  localparam int COLS = 4;
  // one bank lane per grid row
  // lane j also carries column j of B, so COLS must equal LANES
  localparam int LANES = ROWS;

  // data word, products and sums wrap at 32 bits
  localparam int DATA_DW = 32;
  typedef logic signed [DATA_DW-1:0] word_t;

  // bank address, 64 words per lane
  localparam int AW = 6;
  typedef logic [AW-1:0] addr_t;

  // per-lane memory map
  // lane i holds row i of A
  localparam int A_BASE = 0;
  // lane j holds column j of B
  localparam int B_BASE = 16;
  // lane i receives row i of C
  localparam int C_BASE = 32;

  // inner dimension limits
  localparam int K_MAX = 16;
  localparam int KW = 5;

  // last bank read until the far corner cell sees its last pair
  localparam int FLUSH_LEN = ROWS + COLS - 1;

  // sequencer phases
  typedef enum logic [2:0] {
    IDLE,
    FEED,
    FLUSH,
    DRAIN,
    DONE
  } seq_state_t;

endpackage
